// File: tb.f
logic/decode_pkg.sv
logic/imm_gen.sv
logic/func_decode.sv
logic/opcode_decode.sv
logic/decode_buffer.sv
logic/decode_stage.sv
verification/decode_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - logic/decode_pkg.sv
  - logic/imm_gen.sv
  - logic/func_decode.sv
  - logic/opcode_decode.sv
  - logic/decode_buffer.sv
  - logic/decode_stage.sv
  - target: test
    files:
      - verification/decode_tb.sv

// File: verification/decode_tb.sv
/*
 * Decode stage testbench
 * Directed tests for ALU, control flow, memory, CSR, back-pressure
 * and edge cases, checked against a reference decoder model
 */
module decode_tb import decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WID_W       = $clog2(4);
    localparam int NT          = 4;
    localparam int TOTAL_INSTR = 30 + 15 + 15 + 3 + 3;

    logic             clk;
    logic             rst;
    logic             fetch_valid;
    logic             fetch_ready;
    fetch_t           fetch_data;
    logic [WID_W-1:0] fetch_wid;
    logic [NT-1:0]    fetch_tmask;
    logic             out_valid;
    logic             out_ready;
    dec_out_t         out_data;
    logic [WID_W-1:0] out_wid;
    logic [NT-1:0]    out_tmask;
    logic             sched_valid;
    logic [WID_W-1:0] sched_wid;
    logic             sched_wstall;

    integer seed = 98;
    int     errors = 0;
    int     errors_at_start;
    int     tests_passed = 0;
    int     tests_failed = 0;
    uuid_t  next_uuid = 16'h0100;

    decode_stage dut0 (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_data   (fetch_data),
        .fetch_wid    (fetch_wid),
        .fetch_tmask  (fetch_tmask),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .out_wid      (out_wid),
        .out_tmask    (out_tmask),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_wstall (sched_wstall)
    );

    always #50 clk = ~clk;

    // Sign-extend the low bits of v
    function automatic xlen_t sext(input logic [31:0] v, input int bits);
        return xlen_t'($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    function automatic op_t alu_code(input logic [2:0] f3, input logic sub_ok, input logic f7b5);
        case (f3)
            3'd0: return (sub_ok && f7b5) ? op_t'(ALU_SUB) : op_t'(ALU_ADD);
            3'd1: return op_t'(ALU_SLL);
            3'd2: return op_t'(ALU_SLT);
            3'd3: return op_t'(ALU_SLTU);
            3'd4: return op_t'(ALU_XOR);
            3'd5: return f7b5 ? op_t'(ALU_SRA) : op_t'(ALU_SRL);
            3'd6: return op_t'(ALU_OR);
            default: return op_t'(ALU_AND);
        endcase
    endfunction

    function automatic op_t branch_code(input logic [2:0] f3);
        case (f3)
            3'd1: return op_t'(BR_NE);
            3'd4: return op_t'(BR_LT);
            3'd5: return op_t'(BR_GE);
            3'd6: return op_t'(BR_LTU);
            3'd7: return op_t'(BR_GEU);
            default: return op_t'(BR_EQ);
        endcase
    endfunction

    function automatic op_t sys_code(input logic [11:0] field);
        case (field)
            12'h001: return op_t'(BR_EBREAK);
            12'h002: return op_t'(BR_URET);
            12'h102: return op_t'(BR_SRET);
            12'h302: return op_t'(BR_MRET);
            default: return op_t'(BR_ECALL);
        endcase
    endfunction

    // Reference model of the decoded record
    function automatic dec_out_t expect_out(input fetch_t f);
        dec_out_t    e;
        logic [31:0] in;
        logic [2:0]  f3;
        logic        writes;
        in       = f.instr;
        f3       = in[14:12];
        writes   = 1'b0;
        e        = '0;
        e.uuid   = f.uuid;
        e.pc     = f.pc;
        e.dec.ex_type = EX_ALU;
        e.dec.op_type = op_t'(ALU_ADD);
        case (in[6:0])
            OP_I: begin
                e.dec.op_type = alu_code(f3, 1'b0, in[30]);
                e.dec.use_imm = 1'b1;
                e.dec.imm     = (f3 == 3'd1 || f3 == 3'd5) ? xlen_t'(in[24:20])
                                                           : sext(in[31:20], 12);
                e.dec.rs1     = in[19:15];
                writes        = 1'b1;
            end
            OP_R: begin
                if (in[25]) begin   // M extension
                    e.dec.op_type = {1'b0, f3};
                    e.dec.op_mod  = 3'b010;
                end else begin
                    e.dec.op_type = alu_code(f3, 1'b1, in[30]);
                end
                e.dec.rs1 = in[19:15];
                e.dec.rs2 = in[24:20];
                writes    = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                e.dec.op_type = (in[6:0] == OP_LUI) ? op_t'(ALU_LUI) : op_t'(ALU_AUIPC);
                e.dec.use_pc  = (in[6:0] == OP_AUIPC);
                e.dec.use_imm = 1'b1;
                e.dec.imm     = {in[31:12], 12'h000};
                writes        = 1'b1;
            end
            OP_JAL: begin
                e.dec.op_type = op_t'(BR_JAL);
                e.dec.op_mod  = 3'b001;
                e.dec.use_pc  = 1'b1;
                e.dec.use_imm = 1'b1;
                e.dec.imm     = sext({in[31], in[19:12], in[20], in[30:21], 1'b0}, 21);
                writes        = 1'b1;
            end
            OP_JALR: begin
                e.dec.op_type = op_t'(BR_JALR);
                e.dec.op_mod  = 3'b001;
                e.dec.use_imm = 1'b1;
                e.dec.imm     = sext(in[31:20], 12);
                e.dec.rs1     = in[19:15];
                writes        = 1'b1;
            end
            OP_B: begin
                e.dec.op_type = branch_code(f3);
                e.dec.op_mod  = 3'b001;
                e.dec.use_pc  = 1'b1;
                e.dec.use_imm = 1'b1;
                e.dec.imm     = sext({in[31], in[7], in[30:25], in[11:8], 1'b0}, 13);
                e.dec.rs1     = in[19:15];
                e.dec.rs2     = in[24:20];
            end
            OP_L, OP_S: begin
                e.dec.ex_type = EX_LSU;
                e.dec.op_type = {in[5], f3};   // Store flag then func3
                e.dec.use_imm = 1'b1;
                e.dec.imm     = in[5] ? sext({in[31:25], in[11:7]}, 12) : sext(in[31:20], 12);
                e.dec.rs1     = in[19:15];
                e.dec.rs2     = in[5] ? in[24:20] : 5'd0;
                writes        = !in[5];
            end
            OP_FENCE: begin
                e.dec.ex_type = EX_LSU;
                e.dec.op_type = 4'd15;
            end
            OP_SYS: begin
                writes = 1'b1;
                if (f3[1:0] != 2'b00) begin
                    e.dec.ex_type = EX_SFU;
                    e.dec.op_type = {2'b00, f3[1:0]};
                    e.dec.use_imm = f3[2];
                    e.dec.imm     = f3[2] ? {15'd0, in[19:15], in[31:20]} : {20'd0, in[31:20]};
                    e.dec.rs1     = f3[2] ? 5'd0 : in[19:15];
                end else begin
                    e.dec.op_type = sys_code(in[31:20]);
                    e.dec.op_mod  = 3'b001;
                    e.dec.use_pc  = 1'b1;
                    e.dec.use_imm = 1'b1;
                    e.dec.imm     = 32'd4;
                end
            end
            default: ;   // Unknown opcode stays a bare ADD
        endcase
        e.dec.rd = writes ? in[11:7] : 5'd0;
        e.dec.wb = writes && (in[11:7] != 5'd0);
        return e;
    endfunction

    function automatic logic expect_stall(input instr_t in);
        case (in[6:0])
            OP_JAL, OP_JALR, OP_B: return 1'b1;
            OP_SYS: return (in[13:12] == 2'b00) || (in[31:20] <= 12'h003);
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_out(input string name, input dec_out_t exp, input dec_out_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_sched(input string name, input logic exp_stall,
                               input logic [WID_W-1:0] exp_wid,
                               input logic act_stall, input logic [WID_W-1:0] act_wid);
        if (act_stall !== exp_stall || act_wid !== exp_wid) begin
            errors++;
            $display("MISMATCH %s: expected wid %0d stall %b actual wid %0d stall %b",
                     name, exp_wid, exp_stall, act_wid, act_stall);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input logic [WID_W-1:0] exp_wid,
                             input logic [NT-1:0] exp_tmask,
                             input logic [WID_W-1:0] act_wid, input logic [NT-1:0] act_tmask);
        if (act_wid !== exp_wid || act_tmask !== exp_tmask) begin
            errors++;
            $display("MISMATCH %s: expected wid %0d tmask %b actual wid %0d tmask %b",
                     name, exp_wid, exp_tmask, act_wid, act_tmask);
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic report_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    task automatic make_fetch(input instr_t instr, output fetch_t f,
                              output logic [WID_W-1:0] w, output logic [NT-1:0] m);
        logic [31:0] rnd;
        rnd     = $random(seed);
        f.uuid  = next_uuid;
        f.pc    = rnd & 32'hffff_fffc;
        f.instr = instr;
        w       = rnd[WID_W+1:2];
        m       = rnd[11:8];
        next_uuid++;
    endtask

    task automatic wait_accept(input string name);
        int cycles;
        cycles = 0;
        #1;
        while (!fetch_ready && cycles < 20) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!fetch_ready) begin
            errors++;
            $display("test %s: fetch_ready stayed low, instruction was never accepted", name);
        end
    endtask

    // One instruction through an idle stage, checked at accept and at output
    task automatic issue_and_check(input string name, input instr_t instr);
        fetch_t           f;
        logic [WID_W-1:0] w;
        logic [NT-1:0]    m;
        int               cycles;
        make_fetch(instr, f, w, m);
        cycles = 0;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_data  = f;
        fetch_wid   = w;
        fetch_tmask = m;
        wait_accept(name);
        check_flag({name, " sched_valid"}, 1'b1, sched_valid);
        check_sched(name, expect_stall(instr), w, sched_wstall, sched_wid);
        @(posedge clk);
        @(negedge clk);
        fetch_valid = 1'b0;
        while (!out_valid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            errors++;
            $display("test %s: no decoded record came out for instr %h", name, instr);
        end
        check_out(name, expect_out(f), out_data);
        check_tag(name, w, m, out_wid, out_tmask);
    endtask

    task automatic test_reset();
        start_test();
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset sched_valid", 1'b0, sched_valid);
        check_flag("reset fetch_ready", 1'b1, fetch_ready);
        report_test("reset");
    endtask

    task automatic test_alu_mul();
        logic [31:0] rnd;
        logic [6:0]  f7_pick [3];
        f7_pick = '{7'h00, 7'h20, 7'h01};
        start_test();
        issue_and_check("alu_mul", {7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OP_R});   // SUB
        issue_and_check("alu_mul", {7'h20, 5'd4, 5'd5, 3'd5, 5'd6, OP_R});   // SRA
        for (int i = 0; i < 14; i++) begin
            rnd = $random(seed);
            issue_and_check("alu_mul", {f7_pick[i % 3], rnd[24:7], OP_R});
        end
        for (int i = 0; i < 10; i++) begin
            rnd = $random(seed);
            issue_and_check("alu_mul", {rnd[31:7], OP_I});
        end
        for (int i = 0; i < 2; i++) begin
            rnd = $random(seed);
            issue_and_check("alu_mul", {rnd[31:7], OP_LUI});
            issue_and_check("alu_mul", {rnd[31:7], OP_AUIPC});
        end
        report_test("alu_mul");
    endtask

    task automatic test_control();
        logic [31:0] rnd;
        logic [2:0]  br_f3 [6];
        logic [11:0] sys_f [5];
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        sys_f = '{12'h000, 12'h001, 12'h002, 12'h102, 12'h302};
        start_test();
        foreach (br_f3[i]) begin
            rnd = $random(seed);
            issue_and_check("control", {rnd[31:15], br_f3[i], rnd[11:7], OP_B});
        end
        for (int i = 0; i < 2; i++) begin
            rnd = $random(seed);
            issue_and_check("control", {rnd[31:7], OP_JAL});
            issue_and_check("control", {rnd[31:15], 3'd0, rnd[11:7], OP_JALR});
        end
        foreach (sys_f[i])
            issue_and_check("control", {sys_f[i], 13'd0, OP_SYS});
        report_test("control");
    endtask

    task automatic test_mem_csr();
        logic [31:0] rnd;
        logic [2:0]  ld_f3  [5];
        logic [2:0]  csr_f3 [6];
        logic [11:0] addr   [6];
        ld_f3  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        csr_f3 = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
        addr   = '{12'h000, 12'h003, 12'h004, 12'h300, 12'h001, 12'hc00};
        start_test();
        foreach (ld_f3[i]) begin
            rnd = $random(seed);
            issue_and_check("mem_csr", {rnd[31:15], ld_f3[i], rnd[11:7], OP_L});
            if (i < 3)
                issue_and_check("mem_csr", {rnd[31:15], ld_f3[i], rnd[11:7], OP_S});
        end
        rnd = $random(seed);
        issue_and_check("mem_csr", {rnd[31:7], OP_FENCE});
        foreach (csr_f3[i]) begin
            rnd = $random(seed);
            issue_and_check("mem_csr", {addr[i], rnd[19:15], csr_f3[i], rnd[11:7], OP_SYS});
        end
        report_test("mem_csr");
    endtask

    task automatic test_back_pressure();
        fetch_t           f [3];
        logic [WID_W-1:0] w [3];
        logic [NT-1:0]    m [3];
        logic [31:0]      rnd;
        start_test();
        rnd = $random(seed);
        make_fetch({7'h00, rnd[24:7], OP_R}, f[0], w[0], m[0]);
        make_fetch({rnd[31:15], 3'd2, rnd[11:7], OP_L}, f[1], w[1], m[1]);
        make_fetch({rnd[31:15], 3'd4, rnd[11:7], OP_I}, f[2], w[2], m[2]);
        @(negedge clk);
        out_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            fetch_valid = 1'b1;
            fetch_data  = f[i];
            fetch_wid   = w[i];
            fetch_tmask = m[i];
            #1;
            check_flag("back_pressure fetch_ready", i < 2, fetch_ready);
            check_flag("back_pressure sched_valid", i < 2, sched_valid);
            @(negedge clk);
        end
        #1;
        check_flag("back_pressure fetch_ready held", 1'b0, fetch_ready);
        check_out("back_pressure", expect_out(f[0]), out_data);
        check_tag("back_pressure", w[0], m[0], out_wid, out_tmask);
        out_ready = 1'b1;
        @(negedge clk);
        #1;
        check_out("back_pressure", expect_out(f[1]), out_data);
        check_tag("back_pressure", w[1], m[1], out_wid, out_tmask);
        check_flag("back_pressure fetch_ready", 1'b1, fetch_ready);
        @(negedge clk);
        fetch_valid = 1'b0;
        #1;
        check_flag("back_pressure out_valid", 1'b1, out_valid);
        check_out("back_pressure", expect_out(f[2]), out_data);
        check_tag("back_pressure", w[2], m[2], out_wid, out_tmask);
        @(negedge clk);
        check_flag("back_pressure drained", 1'b0, out_valid);
        report_test("back_pressure");
    endtask

    task automatic test_edge();
        logic [31:0] rnd;
        start_test();
        rnd = $random(seed);
        issue_and_check("edge", {rnd[31:15], 3'd0, 5'd0, OP_I});   // ADDI to x0
        check_flag("edge wb x0", 1'b0, out_data.dec.wb);
        issue_and_check("edge", {7'h00, rnd[24:15], 3'd0, 5'd0, OP_R});
        check_flag("edge wb x0", 1'b0, out_data.dec.wb);
        issue_and_check("edge", {rnd[31:7], 7'b1111111});
        check_flag("edge unknown wb", 1'b0, out_data.dec.wb);
        check_flag("edge unknown use_pc", 1'b0, out_data.dec.use_pc);
        check_flag("edge unknown use_imm", 1'b0, out_data.dec.use_imm);
        check_flag("edge unknown op_mod", 1'b0, |out_data.dec.op_mod);
        report_test("edge");
    endtask

    // Watchdog sized from the instruction count
    initial begin
        #(TOTAL_INSTR * 10 * 100 + 2000);
        $display("timeout: the tests did not finish in the allowed time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        fetch_wid   = '0;
        fetch_tmask = '0;
        out_ready   = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst       = 1'b0;
        out_ready = 1'b1;
        #1;
        test_reset();
        test_alu_mul();
        test_control();
        test_mem_csr();
        test_back_pressure();
        test_edge();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: logic/decode_stage.sv
/*
 * Decode stage top
 * Decodes one fetched instruction per cycle, buffers the record
 * for issue and reports warp stalls to the scheduler
 */
module decode_stage import decode_pkg::*; #(
    parameter int NUM_WARPS   = 4,
    parameter int NUM_THREADS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_valid,
    output logic                         fetch_ready,
    input  fetch_t                       fetch_data,
    input  logic [$clog2(NUM_WARPS)-1:0] fetch_wid,
    input  logic [NUM_THREADS-1:0]       fetch_tmask,
    output logic                         out_valid,
    input  logic                         out_ready,
    output dec_out_t                     out_data,
    output logic [$clog2(NUM_WARPS)-1:0] out_wid,
    output logic [NUM_THREADS-1:0]       out_tmask,
    output logic                         sched_valid,
    output logic [$clog2(NUM_WARPS)-1:0] sched_wid,
    output logic                         sched_wstall
);

    xlen_t    i_imm, s_imm, b_imm, u_imm, j_imm, csr_imm;
    op_t      alu_op, br_op, sys_op, mul_op;
    decoded_t dec;
    logic     wstall;
    dec_out_t buf_in;

    imm_gen u_imm_gen (
        .instr   (fetch_data.instr),
        .i_imm   (i_imm),
        .s_imm   (s_imm),
        .b_imm   (b_imm),
        .u_imm   (u_imm),
        .j_imm   (j_imm),
        .csr_imm (csr_imm)
    );

    func_decode u_func_decode (
        .instr  (fetch_data.instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op),
        .mul_op (mul_op)
    );

    opcode_decode u_opcode_decode (
        .instr   (fetch_data.instr),
        .i_imm   (i_imm),
        .s_imm   (s_imm),
        .b_imm   (b_imm),
        .u_imm   (u_imm),
        .j_imm   (j_imm),
        .csr_imm (csr_imm),
        .alu_op  (alu_op),
        .br_op   (br_op),
        .sys_op  (sys_op),
        .mul_op  (mul_op),
        .dec     (dec),
        .wstall  (wstall)
    );

    assign buf_in.uuid = fetch_data.uuid;
    assign buf_in.pc   = fetch_data.pc;
    assign buf_in.dec  = dec;

    decode_buffer #(
        .NUM_WARPS   (NUM_WARPS),
        .NUM_THREADS (NUM_THREADS)
    ) u_decode_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (buf_in),
        .in_wid    (fetch_wid),
        .in_tmask  (fetch_tmask),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_wid   (out_wid),
        .out_tmask (out_tmask)
    );

    // Scheduler hears about every accepted instruction
    assign sched_valid  = fetch_valid && fetch_ready;
    assign sched_wid    = fetch_wid;
    assign sched_wstall = wstall;

endmodule

// File: logic/decode_buffer.sv
/*
 * Decode output buffer
 * Two-entry valid/ready FIFO for decoded records with their
 * warp id and thread mask
 */
module decode_buffer import decode_pkg::*; #(
    parameter int NUM_WARPS   = 4,
    parameter int NUM_THREADS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  dec_out_t                     in_data,
    input  logic [$clog2(NUM_WARPS)-1:0] in_wid,
    input  logic [NUM_THREADS-1:0]       in_tmask,
    output logic                         out_valid,
    input  logic                         out_ready,
    output dec_out_t                     out_data,
    output logic [$clog2(NUM_WARPS)-1:0] out_wid,
    output logic [NUM_THREADS-1:0]       out_tmask
);

    dec_out_t                     data_q  [2];
    logic [$clog2(NUM_WARPS)-1:0] wid_q   [2];
    logic [NUM_THREADS-1:0]       tmask_q [2];
    logic                         wr_ptr;
    logic                         rd_ptr;
    logic [1:0]                   count;
    logic                         push;
    logic                         pop;

    assign in_ready  = (count != 2'd2);   // Independent of out_ready
    assign out_valid = (count != 2'd0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            if (push && !pop)
                count <= count + 2'd1;
            else if (pop && !push)
                count <= count - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[wr_ptr]  <= in_data;
            wid_q[wr_ptr]   <= in_wid;
            tmask_q[wr_ptr] <= in_tmask;
        end
    end

    assign out_data  = data_q[rd_ptr];
    assign out_wid   = wid_q[rd_ptr];
    assign out_tmask = tmask_q[rd_ptr];

    // A push must never land on an entry that is still waiting
    no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count == 2'd0 || wr_ptr != rd_ptr))
        else $error("decode buffer written while full");

    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_wid)
            && $stable(out_tmask)))
        else $error("decode output changed under back-pressure");

endmodule

// File: logic/opcode_decode.sv
/*
 * Major opcode decoder
 * Selects unit, operation, modifier, immediate and register usage
 * for RV32IM, and flags instructions that must stall their warp
 */
module opcode_decode import decode_pkg::*; (
    input  instr_t   instr,
    input  xlen_t    i_imm,
    input  xlen_t    s_imm,
    input  xlen_t    b_imm,
    input  xlen_t    u_imm,
    input  xlen_t    j_imm,
    input  xlen_t    csr_imm,
    input  op_t      alu_op,
    input  op_t      br_op,
    input  op_t      sys_op,
    input  op_t      mul_op,
    output decoded_t dec,
    output logic     wstall
);

    opcode_e     opcode;
    logic [2:0]  func3;
    logic [6:0]  func7;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        use_rd;

    assign opcode = opcode_e'(instr[6:0]);
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        dec         = '0;
        dec.ex_type = EX_ALU;
        dec.op_type = op_t'(ALU_ADD);
        use_rd      = 1'b0;
        wstall      = 1'b0;

        case (opcode)
            OP_I: begin
                dec.op_type = alu_op;
                dec.use_imm = 1'b1;
                dec.imm     = i_imm;
                dec.rs1     = rs1;
                use_rd      = 1'b1;
            end
            OP_R: begin
                if (func7[0]) begin
                    dec.op_type   = mul_op;
                    dec.op_mod[1] = 1'b1;
                end else begin
                    dec.op_type = alu_op;
                end
                dec.rs1 = rs1;
                dec.rs2 = rs2;
                use_rd  = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                dec.op_type = (opcode == OP_LUI) ? op_t'(ALU_LUI) : op_t'(ALU_AUIPC);
                dec.use_pc  = (opcode == OP_AUIPC);
                dec.use_imm = 1'b1;
                dec.imm     = u_imm;
                use_rd      = 1'b1;
            end
            OP_JAL: begin
                dec.op_type   = op_t'(BR_JAL);
                dec.op_mod[0] = 1'b1;
                dec.use_pc    = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = j_imm;
                use_rd        = 1'b1;
                wstall        = 1'b1;
            end
            OP_JALR: begin
                dec.op_type   = op_t'(BR_JALR);
                dec.op_mod[0] = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = i_imm;
                dec.rs1       = rs1;
                use_rd        = 1'b1;
                wstall        = 1'b1;
            end
            OP_B: begin
                dec.op_type   = br_op;
                dec.op_mod[0] = 1'b1;
                dec.use_pc    = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = b_imm;
                dec.rs1       = rs1;
                dec.rs2       = rs2;
                wstall        = 1'b1;
            end
            OP_L: begin
                dec.ex_type = EX_LSU;
                dec.op_type = {1'b0, func3};
                dec.use_imm = 1'b1;
                dec.imm     = i_imm;
                dec.rs1     = rs1;
                use_rd      = 1'b1;
            end
            OP_S: begin
                dec.ex_type = EX_LSU;
                dec.op_type = {1'b1, func3};
                dec.use_imm = 1'b1;
                dec.imm     = s_imm;
                dec.rs1     = rs1;
                dec.rs2     = rs2;
            end
            OP_FENCE: begin
                dec.ex_type = EX_LSU;
                dec.op_type = LSU_FENCE;
            end
            OP_SYS: begin
                use_rd = 1'b1;
                if (func3[1:0] != 2'b00) begin   // CSR access
                    dec.ex_type = EX_SFU;
                    dec.op_type = {2'b00, func3[1:0]};
                    dec.use_imm = func3[2];
                    dec.imm     = func3[2] ? csr_imm : {20'b0, csr_imm[11:0]};
                    dec.rs1     = func3[2] ? '0 : rs1;
                    wstall      = (instr[31:20] <= CSR_STALL_MAX);
                end else begin
                    dec.op_type   = sys_op;
                    dec.op_mod[0] = 1'b1;
                    dec.use_pc    = 1'b1;
                    dec.use_imm   = 1'b1;
                    dec.imm       = 32'd4;   // Return address offset
                    wstall        = 1'b1;
                end
            end
            default: ;
        endcase

        dec.rd = use_rd ? rd : '0;
        dec.wb = use_rd && (rd != '0);
    end

    // Only opcodes with an rd field write back, and never to x0
    always_comb begin
        wb_rd_check: assert final (!dec.wb || (dec.rd != '0 && opcode inside {
            OP_I, OP_R, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_L, OP_SYS}))
            else $error("wb set with rd=%0d for instr %h", dec.rd, instr);
    end

endmodule

// File: logic/func_decode.sv
/*
 * Function field decoder
 * Maps func3/func7 and the system field to ALU, branch,
 * system and multiply/divide operation codes
 */
module func_decode import decode_pkg::*; (
    input  instr_t instr,
    output op_t    alu_op,
    output op_t    br_op,
    output op_t    sys_op,
    output op_t    mul_op
);

    logic [2:0]  func3;
    logic [6:0]  func7;
    logic [11:0] sys_field;
    mul_op_e     mul_sel;

    assign func3     = instr[14:12];
    assign func7     = instr[31:25];
    assign sys_field = instr[31:20];

    always_comb begin
        case (func3)
            3'h0: alu_op = (instr[5] && func7[5]) ? op_t'(ALU_SUB) : op_t'(ALU_ADD);
            3'h1: alu_op = op_t'(ALU_SLL);
            3'h2: alu_op = op_t'(ALU_SLT);
            3'h3: alu_op = op_t'(ALU_SLTU);
            3'h4: alu_op = op_t'(ALU_XOR);
            3'h5: alu_op = func7[5] ? op_t'(ALU_SRA) : op_t'(ALU_SRL);
            3'h6: alu_op = op_t'(ALU_OR);
            default: alu_op = op_t'(ALU_AND);
        endcase
    end

    always_comb begin
        case (func3)
            3'h0: br_op = op_t'(BR_EQ);
            3'h1: br_op = op_t'(BR_NE);
            3'h4: br_op = op_t'(BR_LT);
            3'h5: br_op = op_t'(BR_GE);
            3'h6: br_op = op_t'(BR_LTU);
            3'h7: br_op = op_t'(BR_GEU);
            default: br_op = op_t'(BR_EQ);   // Reserved encodings
        endcase
    end

    always_comb begin
        case (sys_field)
            12'h001: sys_op = op_t'(BR_EBREAK);
            12'h002: sys_op = op_t'(BR_URET);
            12'h102: sys_op = op_t'(BR_SRET);
            12'h302: sys_op = op_t'(BR_MRET);
            default: sys_op = op_t'(BR_ECALL);
        endcase
    end

    assign mul_sel = mul_op_e'({1'b0, func3});
    assign mul_op  = op_t'(mul_sel);

endmodule

// File: logic/imm_gen.sv
/*
 * Immediate generator
 * Builds the sign-extended I, S, B, U and J immediates and the
 * packed CSR address/zimm word from one instruction
 */
module imm_gen import decode_pkg::*; (
    input  instr_t instr,
    output xlen_t  i_imm,
    output xlen_t  s_imm,
    output xlen_t  b_imm,
    output xlen_t  u_imm,
    output xlen_t  j_imm,
    output xlen_t  csr_imm
);

    logic [2:0]  func3;
    logic        is_shift_imm;
    logic [11:0] b_raw;
    logic [19:0] j_raw;

    assign func3 = instr[14:12];

    // SLLI, SRLI, SRAI carry only a shift amount
    assign is_shift_imm = (instr[6:0] == OP_I) && (func3[1:0] == 2'b01);

    assign i_imm = is_shift_imm ? {27'b0, instr[24:20]}
                                : {{20{instr[31]}}, instr[31:20]};

    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    assign b_raw = {instr[31], instr[7], instr[30:25], instr[11:8]};
    assign b_imm = {{19{b_raw[11]}}, b_raw, 1'b0};

    assign u_imm = {instr[31:12], 12'b0};

    assign j_raw = {instr[31], instr[19:12], instr[20], instr[30:21]};
    assign j_imm = {{11{j_raw[19]}}, j_raw, 1'b0};

    assign csr_imm = {15'b0, instr[19:15], instr[31:20]};   // zimm above address

endmodule

// File: logic/decode_pkg.sv
/*
 * Decode package
 * ISA field types, opcode, unit and operation encodings, and the
 * fetch and decoded record layouts shared by the decode stage
 */
package decode_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] uuid_t;
    typedef logic [3:0]  op_t;
    typedef logic [2:0]  op_mod_t;   // [0] branch, [1] mul/div, [2] unused

    typedef enum logic [6:0] {
        OP_I     = 7'b0010011,
        OP_R     = 7'b0110011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111,
        OP_B     = 7'b1100011,
        OP_L     = 7'b0000011,
        OP_S     = 7'b0100011,
        OP_FENCE = 7'b0001111,
        OP_SYS   = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_unit_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    // Same order as func3
    typedef enum logic [3:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU,
        MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
    } mul_op_e;

    localparam op_t LSU_FENCE = 4'd15;              // Loads/stores are {store, func3}
    localparam logic [11:0] CSR_STALL_MAX = 12'h003;

    typedef struct packed {
        uuid_t  uuid;
        xlen_t  pc;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        ex_unit_e ex_type;
        op_t      op_type;
        op_mod_t  op_mod;
        logic     use_pc;
        logic     use_imm;
        xlen_t    imm;
        logic     wb;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } decoded_t;

    typedef struct packed {
        uuid_t    uuid;
        xlen_t    pc;
        decoded_t dec;
    } dec_out_t;

endpackage
